// ==== logic/dcache_port_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

// single cache port shared by drain and load path
module dcache_port_arbiter (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            stb_empty_i,    // queue empty, no drain pending

    dcache_req_if.port      drain,          // store drain requester
    dcache_req_if.port      load,           // lsu load requester
    dcache_req_if.requester cache           // toward dc_* pins
);

    stb_bus_pkg::req_kind_e owner_q;        // grant held until ack
    stb_bus_pkg::req_kind_e cur;            // effective owner this cycle

    // new choice only while idle, drain first
    always_comb begin
        cur = owner_q;
        if (owner_q == stb_bus_pkg::REQ_NONE) begin
            if (drain.req) begin
                cur = stb_bus_pkg::REQ_DRAIN;
            end else if (load.req && stb_empty_i) begin
                cur = stb_bus_pkg::REQ_LOAD;   // loads see every earlier store
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_q <= stb_bus_pkg::REQ_NONE;
        end else if (cache.ack) begin
            owner_q <= stb_bus_pkg::REQ_NONE;  // release on ack
        end else begin
            owner_q <= cur;
        end
    end

    // route owner to cache, ack/rdata back to owner only
    always_comb begin
        cache.req      = 1'b0;
        cache.w_en     = 1'b0;
        cache.addr     = '0;
        cache.wdata    = '0;
        cache.sel_byte = '0;
        drain.ack      = 1'b0;
        drain.rdata    = '0;
        load.ack       = 1'b0;
        load.rdata     = '0;
        case (cur)
            stb_bus_pkg::REQ_DRAIN: begin
                cache.req      = drain.req;
                cache.w_en     = drain.w_en;
                cache.addr     = drain.addr;
                cache.wdata    = drain.wdata;
                cache.sel_byte = drain.sel_byte;
                drain.ack      = cache.ack;
                drain.rdata    = cache.rdata;
            end
            stb_bus_pkg::REQ_LOAD: begin
                cache.req      = load.req;
                cache.w_en     = load.w_en;
                cache.addr     = load.addr;
                cache.wdata    = load.wdata;
                cache.sel_byte = load.sel_byte;
                load.ack       = cache.ack;
                load.rdata     = cache.rdata;
            end
            default: ;                     // port idle
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/dcache_req_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one requester on a cache port, req/ack handshake
interface dcache_req_if;

    logic                               req;       // held until ack
    logic                               w_en;      // 1 store, 0 load
    logic [stb_cfg_pkg::ADDR_W-1:0]     addr;
    logic [stb_cfg_pkg::DATA_W-1:0]     wdata;
    logic [stb_cfg_pkg::BYTES_W-1:0]    sel_byte;
    logic                               ack;       // single cycle
    logic [stb_cfg_pkg::DATA_W-1:0]     rdata;     // valid with ack on loads

    modport requester (
        output req, w_en, addr, wdata, sel_byte,
        input  ack, rdata
    );

    modport port (
        input  req, w_en, addr, wdata, sel_byte,
        output ack, rdata
    );

endinterface

`default_nettype wire

// ==== logic/lsu_stb_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

// store accept with one push per held request and a registered ack
module lsu_stb_ctrl (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    st_req_i,   // lsu store request held until ack
    input  logic    full_i,     // queue has no room

    output logic    push_o,     // write entry into queue
    output logic    ack_o       // store accepted for one cycle
);

    typedef enum logic {
        ST_IDLE = 1'b0,     // waiting for a store
        ST_ACK  = 1'b1      // ack cycle, request still held
    } state_e;

    state_e state_q;
    state_e state_d;

    // push only from idle so a held request lands once
    assign push_o = st_req_i & ~full_i & (state_q == ST_IDLE);

    always_comb begin
        state_d = ST_IDLE;          // ack lasts exactly one cycle
        if (push_o) begin
            state_d = ST_ACK;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign ack_o = (state_q == ST_ACK);    // registered one cycle after push

endmodule

`default_nettype wire

// ==== logic/stb_bus_pkg.sv ====
`default_nettype none

package stb_bus_pkg;

    // one buffered store, 68 bits
    typedef struct packed {
        logic [stb_cfg_pkg::ADDR_W-1:0]  addr;      // target word address
        logic [stb_cfg_pkg::DATA_W-1:0]  wdata;     // store data
        logic [stb_cfg_pkg::BYTES_W-1:0] sel_byte;  // byte enables
    } stb_entry_s;

    // current owner of the cache port
    typedef enum logic [1:0] {
        REQ_NONE  = 2'd0,   // port idle
        REQ_DRAIN = 2'd1,   // store drain
        REQ_LOAD  = 2'd2    // lsu load
    } req_kind_e;

endpackage

`default_nettype wire

// ==== logic/stb_cfg_pkg.sv ====
`default_nettype none

package stb_cfg_pkg;

    localparam int ADDR_W    = 32;  // cache address
    localparam int DATA_W    = 32;  // data word
    localparam int BYTES_W   = 4;   // byte lanes per word
    localparam int STB_DEPTH = 4;   // store queue entries
    localparam int PTR_W     = 2;   // log2 of depth

    // occupancy needs one bit more than the pointers
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(STB_DEPTH);

endpackage

`default_nettype wire

// ==== logic/stb_drain_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

// drains the queue head to the cache port, one store at a time
module stb_drain_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,

    // from queue
    input  logic                    empty_i,
    input  stb_bus_pkg::stb_entry_s head_i,
    output logic                    pop_o,      // head retired

    dcache_req_if.requester         dc          // toward arbiter
);

    typedef enum logic {
        DR_IDLE = 1'b0,
        DR_BUSY = 1'b1      // request out, waiting for ack
    } drain_state_e;

    drain_state_e            state_q;
    stb_bus_pkg::stb_entry_s entry_q;   // copy of head, stable while busy

    // pop at the same edge the ack is taken
    assign pop_o = (state_q == DR_BUSY) & dc.ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DR_IDLE;
        end else begin
            case (state_q)
                DR_IDLE: if (!empty_i) state_q <= DR_BUSY;  // start next drain
                DR_BUSY: if (dc.ack)   state_q <= DR_IDLE;  // done, reconsider
                default: state_q <= DR_IDLE;
            endcase
        end
    end

    // latch head on the start of a drain
    always_ff @(posedge clk) begin
        if ((state_q == DR_IDLE) && !empty_i) begin
            entry_q <= head_i;
        end
    end

    assign dc.req      = (state_q == DR_BUSY);
    assign dc.w_en     = 1'b1;             // drains are always writes
    assign dc.addr     = entry_q.addr;
    assign dc.wdata    = entry_q.wdata;
    assign dc.sel_byte = entry_q.sel_byte;

endmodule

`default_nettype wire

// ==== logic/stb_entry_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

// in-order store queue in a circular buffer
module stb_entry_fifo (
    input  logic                    clk,
    input  logic                    rst_n,

    // from lsu controller
    input  logic                    push_i,
    input  stb_bus_pkg::stb_entry_s push_entry_i,

    // drain side
    input  logic                    pop_i,
    output stb_bus_pkg::stb_entry_s head_o,        // oldest store read combinationally

    output logic                    full_o,
    output logic                    empty_o
);

    stb_bus_pkg::stb_entry_s        mem [stb_cfg_pkg::STB_DEPTH];  // entry storage

    logic [stb_cfg_pkg::PTR_W-1:0]  wr_ptr;     // next free slot
    logic [stb_cfg_pkg::PTR_W-1:0]  rd_ptr;     // oldest entry
    logic [stb_cfg_pkg::CNT_W-1:0]  count;      // occupancy

    logic                           do_push;
    logic                           do_pop;

    // guard against misuse at the edges
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    assign full_o  = (count == stb_cfg_pkg::FULL_CNT);
    assign empty_o = (count == '0);

    assign head_o  = mem[rd_ptr];

    // payload write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry_i;
        end
    end

    // pointers wrap naturally at depth 4
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;    // fill
                2'b01:   count <= count - 1'b1;    // drain
                default: count <= count;           // none or both
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/stb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// store buffer between lsu and dcache port
module stb_top (
    input  logic                                clk,
    input  logic                                rst_n,

    // lsu request side
    input  logic                                lsu_req_i,
    input  logic                                lsu_w_en_i,      // 1 store, 0 load
    input  logic [stb_cfg_pkg::ADDR_W-1:0]      lsu_addr_i,
    input  logic [stb_cfg_pkg::DATA_W-1:0]      lsu_wdata_i,
    input  logic [stb_cfg_pkg::BYTES_W-1:0]     lsu_sel_byte_i,
    output logic                                lsu_ack_o,
    output logic [stb_cfg_pkg::DATA_W-1:0]      lsu_rdata_o,

    // dcache port
    output logic                                dc_req_o,
    output logic                                dc_w_en_o,
    output logic [stb_cfg_pkg::ADDR_W-1:0]      dc_addr_o,
    output logic [stb_cfg_pkg::DATA_W-1:0]      dc_wdata_o,
    output logic [stb_cfg_pkg::BYTES_W-1:0]     dc_sel_byte_o,
    input  logic                                dc_ack_i,
    input  logic [stb_cfg_pkg::DATA_W-1:0]      dc_rdata_i,

    output logic                                stb_empty_o
);

    logic                       st_req;     // lsu store
    logic                       push;
    logic                       pop;
    logic                       full;
    logic                       empty;
    logic                       st_ack;     // store accepted
    stb_bus_pkg::stb_entry_s    push_entry;
    stb_bus_pkg::stb_entry_s    head;

    dcache_req_if drain_if ();
    dcache_req_if load_if ();
    dcache_req_if cache_if ();

    assign st_req = lsu_req_i & lsu_w_en_i;

    assign push_entry.addr     = lsu_addr_i;
    assign push_entry.wdata    = lsu_wdata_i;
    assign push_entry.sel_byte = lsu_sel_byte_i;

    // loads bypass the queue, arbiter holds them off until empty
    assign load_if.req      = lsu_req_i & ~lsu_w_en_i;
    assign load_if.w_en     = 1'b0;
    assign load_if.addr     = lsu_addr_i;
    assign load_if.wdata    = lsu_wdata_i;
    assign load_if.sel_byte = lsu_sel_byte_i;

    stb_entry_fifo u_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (push),
        .push_entry_i (push_entry),
        .pop_i        (pop),
        .head_o       (head),
        .full_o       (full),
        .empty_o      (empty)
    );

    lsu_stb_ctrl u_lsu_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_req_i (st_req),
        .full_i   (full),
        .push_o   (push),
        .ack_o    (st_ack)
    );

    stb_drain_ctrl u_drain_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .empty_i (empty),
        .head_i  (head),
        .pop_o   (pop),
        .dc      (drain_if.requester)
    );

    dcache_port_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .stb_empty_i (empty),      // drain busy implies entry still queued
        .drain       (drain_if.port),
        .load        (load_if.port),
        .cache       (cache_if.requester)
    );

    // cache pins
    assign dc_req_o       = cache_if.req;
    assign dc_w_en_o      = cache_if.w_en;
    assign dc_addr_o      = cache_if.addr;
    assign dc_wdata_o     = cache_if.wdata;
    assign dc_sel_byte_o  = cache_if.sel_byte;
    assign cache_if.ack   = dc_ack_i;
    assign cache_if.rdata = dc_rdata_i;

    // store and load acks never overlap, one lsu request at a time
    assign lsu_ack_o   = st_ack | load_if.ack;
    assign lsu_rdata_o = load_if.rdata;
    assign stb_empty_o = empty;

endmodule

`default_nettype wire

// ==== stb_subsystem.f ====
logic/stb_cfg_pkg.sv
logic/stb_bus_pkg.sv
logic/dcache_req_if.sv
logic/stb_entry_fifo.sv
logic/lsu_stb_ctrl.sv
logic/stb_drain_ctrl.sv
logic/dcache_port_arbiter.sv
logic/stb_top.sv
verification/stb_props.sv
verification/stb_tb.sv

// ==== verification/stb_props.sv ====
`timescale 1ns/1ns
`default_nettype none

// handshake and ordering properties on the store buffer pins
module stb_props (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            lsu_req_i,
    input  logic                            lsu_ack_i,      // dut lsu_ack_o
    input  logic                            dc_req_i,       // dut dc_req_o
    input  logic                            dc_w_en_i,
    input  logic [stb_cfg_pkg::ADDR_W-1:0]  dc_addr_i,
    input  logic [stb_cfg_pkg::DATA_W-1:0]  dc_wdata_i,
    input  logic [stb_cfg_pkg::BYTES_W-1:0] dc_sel_byte_i,
    input  logic                            dc_ack_i,
    input  logic                            stb_empty_i
);

    int fail_count = 0;     // failed property evaluations

    // waiting request keeps its fields until the ack edge
    a_dc_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (dc_req_i && !dc_ack_i) |=> (dc_req_i && $stable(dc_w_en_i) && $stable(dc_addr_i)
            && $stable(dc_wdata_i) && $stable(dc_sel_byte_i)))
        else begin
            fail_count++;
            $error("dc request dropped or changed before its ack");
        end

    // loads only reach the cache with the queue empty
    a_load_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (dc_req_i && !dc_w_en_i) |-> stb_empty_i)
        else begin
            fail_count++;
            $error("load on dc port while store queue not empty");
        end

    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(lsu_ack_i) |-> lsu_req_i)
        else begin
            fail_count++;
            $error("lsu ack raised without a pending request");
        end

    a_reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> stb_empty_i)
        else begin
            fail_count++;
            $error("store queue not empty right after reset");
        end

endmodule

bind stb_top stb_props u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .lsu_req_i     (lsu_req_i),
    .lsu_ack_i     (lsu_ack_o),
    .dc_req_i      (dc_req_o),
    .dc_w_en_i     (dc_w_en_o),
    .dc_addr_i     (dc_addr_o),
    .dc_wdata_i    (dc_wdata_o),
    .dc_sel_byte_i (dc_sel_byte_o),
    .dc_ack_i      (dc_ack_i),
    .stb_empty_i   (stb_empty_o)
);

`default_nettype wire

// ==== verification/stb_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module stb_tb;

    localparam int N_OPS      = 200;                    // random lsu operations
    localparam int MAX_CYCLES = N_OPS * 20;             // worst case per op incl. stall
    localparam int DEPTH      = stb_cfg_pkg::STB_DEPTH;

    logic                            clk;
    logic                            rst_n;
    logic                            lsu_req_i;
    logic                            lsu_w_en_i;
    logic [stb_cfg_pkg::ADDR_W-1:0]  lsu_addr_i;
    logic [stb_cfg_pkg::DATA_W-1:0]  lsu_wdata_i;
    logic [stb_cfg_pkg::BYTES_W-1:0] lsu_sel_byte_i;
    logic                            lsu_ack_o;
    logic [stb_cfg_pkg::DATA_W-1:0]  lsu_rdata_o;
    logic                            dc_req_o;
    logic                            dc_w_en_o;
    logic [stb_cfg_pkg::ADDR_W-1:0]  dc_addr_o;
    logic [stb_cfg_pkg::DATA_W-1:0]  dc_wdata_o;
    logic [stb_cfg_pkg::BYTES_W-1:0] dc_sel_byte_o;
    logic                            dc_ack_i;
    logic [stb_cfg_pkg::DATA_W-1:0]  dc_rdata_i;
    logic                            stb_empty_o;

    logic [15:0]             lfsr_q = 16'd54;
    logic [31:0]             cache_mem [8];     // cache model contents
    logic [31:0]             exp_mem [8];       // memory as the lsu should see it
    stb_bus_pkg::stb_entry_s exp_drain [$];     // acked stores not yet written
    stb_bus_pkg::stb_entry_s exp_e;
    int   err_count = 0;
    int   chk_count = 0;
    int   cycle_cnt = 0;
    int   req_age   = 0;        // edges seen with current lsu request
    int   occ_pre   = 0;
    int   occ_prev  = 0;        // queue fill before the previous edge
    int   stall_cycles = 0;     // cache holds acks while nonzero
    logic full_at_req = 1'b0;
    logic op_done     = 1'b0;   // set at the lsu handshake edge
    logic ack_nxt     = 1'b0;
    logic busy        = 1'b0;
    logic [1:0]  delay_q   = '0;
    logic [31:0] rdata_nxt = '0;

    stb_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 16-bit fibonacci lfsr x^16+x^14+x^13+x^11+1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [3:0] sel);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) r[8*b +: 8] = wd[8*b +: 8];   // only enabled lanes
        end
        return r;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        chk_count++;
        assert (got === exp) else begin
            err_count++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic close_run();
        err_count += u_dut.u_props.fail_count;
        $display("errors: %0d  checks: %0d  cycles: %0d", err_count, chk_count, cycle_cnt);
        if (err_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    endtask

    // one lsu request from falling edge to falling edge
    task automatic lsu_op(input logic w, input logic [2:0] idx, input logic [31:0] data,
                          input logic [3:0] sel);
        lsu_req_i      = 1'b1;
        lsu_w_en_i     = w;
        lsu_addr_i     = {29'd0, idx} << 2;
        lsu_wdata_i    = data;
        lsu_sel_byte_i = sel;
        do @(negedge clk); while (!op_done);
        op_done   = 1'b0;
        lsu_req_i = 1'b0;
    endtask

    // cache model decides at the rising edge and drives at the falling edge
    always @(posedge clk) begin
        if (!rst_n) begin
            ack_nxt = 1'b0;
            busy    = 1'b0;
        end else if (dc_ack_i) begin
            if (dc_w_en_o)
                cache_mem[dc_addr_o[4:2]] = merge_bytes(cache_mem[dc_addr_o[4:2]], dc_wdata_o,
                                                        dc_sel_byte_o);
            ack_nxt = 1'b0;     // single cycle ack
            busy    = 1'b0;
        end else if (dc_req_o && stall_cycles == 0) begin
            if (!busy) begin
                busy    = 1'b1;
                delay_q = rand_bits(2);     // 0..3 extra cycles
            end
            if (delay_q == 0) begin
                ack_nxt   = 1'b1;
                rdata_nxt = cache_mem[dc_addr_o[4:2]];
            end else begin
                delay_q--;
            end
        end
        if (stall_cycles > 0) stall_cycles--;
    end

    always @(negedge clk) begin
        dc_ack_i   = ack_nxt;
        dc_rdata_i = rdata_nxt;
    end

    // scoreboard and latency checks
    always @(posedge clk) begin
        if (rst_n) begin
            occ_pre = exp_drain.size();
            if (dc_req_o && dc_ack_i && dc_w_en_o) begin
                if (exp_drain.size() == 0) begin
                    err_count++;
                    $display("error at t=%0t: dc write with no acknowledged store pending", $time);
                end else begin
                    exp_e = exp_drain.pop_front();      // acknowledge order
                    check_eq("dc_addr_o", exp_e.addr, dc_addr_o);
                    check_eq("dc_wdata_o", exp_e.wdata, dc_wdata_o);
                    check_eq("dc_sel_byte_o", exp_e.sel_byte, dc_sel_byte_o);
                end
            end
            if (dc_req_o && !dc_w_en_o) check_eq("stb_empty_o", 1, stb_empty_o);
            if (lsu_req_i) begin
                req_age++;
                if (req_age == 1) full_at_req = (occ_pre == DEPTH);
            end
            if (lsu_req_i && lsu_ack_o) begin
                if (lsu_w_en_i) begin
                    if (!full_at_req) check_eq("lsu_ack_o latency", 2, req_age);
                    chk_count++;
                    assert (occ_prev < DEPTH) else begin
                        err_count++;
                        $display("error at t=%0t: store acknowledged while queue was full", $time);
                    end
                    exp_mem[lsu_addr_i[4:2]] = merge_bytes(exp_mem[lsu_addr_i[4:2]], lsu_wdata_i,
                                                           lsu_sel_byte_i);
                    exp_e.addr     = lsu_addr_i;
                    exp_e.wdata    = lsu_wdata_i;
                    exp_e.sel_byte = lsu_sel_byte_i;
                    exp_drain.push_back(exp_e);
                end else begin
                    check_eq("lsu_rdata_o", exp_mem[lsu_addr_i[4:2]], lsu_rdata_o);
                end
                req_age = 0;
                op_done = 1'b1;
            end
            occ_prev = occ_pre;
        end
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("error: timeout, run did not finish within %0d cycles", MAX_CYCLES);
        err_count++;
        close_run();
    end

    initial begin
        logic        is_load;
        int          i;
        rst_n          = 1'b0;
        lsu_req_i      = 1'b0;
        lsu_w_en_i     = 1'b0;
        lsu_addr_i     = '0;
        lsu_wdata_i    = '0;
        lsu_sel_byte_i = '0;
        dc_ack_i       = 1'b0;
        dc_rdata_i     = '0;
        for (i = 0; i < 8; i++) begin
            cache_mem[i] = {16'hd00d, 16'(i * 4)};   // byte address in low half
            exp_mem[i]   = cache_mem[i];
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("lsu_ack_o", 0, lsu_ack_o);
        check_eq("dc_req_o", 0, dc_req_o);
        check_eq("stb_empty_o", 1, stb_empty_o);

        // with the cache stalled four stores fill the queue and the fifth waits for a drain
        stall_cycles = 30;
        for (i = 0; i < DEPTH + 1; i++)
            lsu_op(1'b1, 3'(i), rand_bits(32), 4'hf);

        // back to back mixed traffic with roughly one load in four
        for (i = 0; i < N_OPS; i++) begin
            is_load = (rand_bits(2) == 0);
            lsu_op(!is_load, rand_bits(3), rand_bits(32), rand_bits(4));
        end

        while (!stb_empty_o || dc_req_o) @(negedge clk);
        check_eq("exp_drain size", 0, exp_drain.size());
        close_run();
    end

endmodule

`default_nettype wire
